// ==== bench/cache_stimulus.txt ====
// columns: address, expected hit (1) or miss (0), expected 64-bit word
// set 0 uses tags A=0x1000, B=0x2000, C=0x3000 to walk the LRU choice
00001000 0 00001000FFFFEFFF
00001008 1 00001008FFFFEFF7
00001010 1 00001010FFFFEFEF
00001018 1 00001018FFFFEFE7
00001000 1 00001000FFFFEFFF
00002018 0 00002018FFFFDFE7
00002000 1 00002000FFFFDFFF
00001008 1 00001008FFFFEFF7
00003000 0 00003000FFFFCFFF
00001010 1 00001010FFFFEFEF
00003008 1 00003008FFFFCFF7
00002000 0 00002000FFFFDFFF
00003000 1 00003000FFFFCFFF
00001000 0 00001000FFFFEFFF
// other sets
12345660 0 12345660EDCBA99F
12345678 1 12345678EDCBA987
12345670 1 12345670EDCBA98F
ABCDE020 0 ABCDE02054321FDF
12345660 1 12345660EDCBA99F
ABCDE028 1 ABCDE02854321FD7
00003008 1 00003008FFFFCFF7
00002000 0 00002000FFFFDFFF

// ==== sim.f ====
src/cachePkg.sv
src/busPkg.sv
src/sramModel.sv
src/refillUnit.sv
src/cacheCtrl.sv
src/cacheTop.sv
bench/clockGen.sv
bench/cache_asserts.sv
bench/cacheTb.sv

// ==== bench/cacheTb.sv ====
`timescale 1ns/100ps

module cacheTb;

  localparam int maxReqs    = 32;
  localparam int stallLimit = 300;

  logic                           clk;
  logic                           rst_n;
  logic                           valid;
  logic [cachePkg::addrWidth-1:0] addr;
  logic                           addrOk;
  logic                           dataOk;
  logic [cachePkg::wordWidth-1:0] rdData;
  logic                           rdReqValid;
  logic [cachePkg::addrWidth-1:0] rdAddr;
  logic                           rdReqReady;
  logic                           rdDataValid;
  logic [busPkg::beatWidth-1:0]   rdBeat;
  logic                           rdLast;

  logic [63:0]                    stimMem [3*maxReqs];
  logic [cachePkg::addrWidth-1:0] stimAddr [maxReqs];
  logic                           expHit [maxReqs];
  logic [cachePkg::wordWidth-1:0] expWord [maxReqs];
  int                             acceptCyc [maxReqs];
  int                             reqMark [maxReqs];
  int                             riseMark [maxReqs];
  int                             pending [$];
  int                             numReqs;
  int                             cyc;
  int                             reqCycles;
  int                             reqRises;
  logic                           prevReqValid;
  logic [cachePkg::addrWidth-1:0] lastReqAddr;

  integer                         seed;
  logic                           handshakeDue;
  logic                           beatsActive;
  int                             beatIdx;
  logic [cachePkg::addrWidth-1:0] busAddr;
  logic [cachePkg::addrWidth-1:0] beatAddr;

  clockGen clkGen_i (
    .clk_o(clk)
  );

  cacheTop #(
    .numSets(cachePkg::numSets)
  ) dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (valid),
    .addr_i       (addr),
    .addrOk_o     (addrOk),
    .dataOk_o     (dataOk),
    .rdData_o     (rdData),
    .rdReqValid_o (rdReqValid),
    .rdAddr_o     (rdAddr),
    .rdReqReady_i (rdReqReady),
    .rdDataValid_i(rdDataValid),
    .rdData_i     (rdBeat),
    .rdLast_i     (rdLast)
  );

  task automatic reportFail(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic checkValue(input string name, input logic [63:0] actual,
                            input logic [63:0] expected);
    if (actual !== expected) begin
      reportFail($sformatf("ERROR: %s expected 0x%0h got 0x%0h", name, expected, actual));
    end
  endtask

  task automatic loadStimulus();
    // unloaded entries keep a nonzero upper half that loaded addresses never have
    for (int i = 0; i < 3 * maxReqs; i++) begin
      stimMem[i] = {~32'(i), 32'(i)};
    end
    $readmemh("bench/cache_stimulus.txt", stimMem);
    numReqs = 0;
    while (numReqs < maxReqs && stimMem[3*numReqs][63:32] == '0) begin
      stimAddr[numReqs] = stimMem[3*numReqs][cachePkg::addrWidth-1:0];
      expHit[numReqs]   = stimMem[3*numReqs+1][0];
      expWord[numReqs]  = stimMem[3*numReqs+2];
      numReqs++;
    end
    if (numReqs == 0) begin
      reportFail("no requests found in the stimulus file");
    end
  endtask

  task automatic retireCheck(input int idx);
    checkValue("rdData_o", rdData, expWord[idx]);
    if (expHit[idx]) begin
      checkValue("dataOk_o latency", cyc - acceptCyc[idx], 1);
      checkValue("rdReqValid_o cycles", reqCycles - reqMark[idx], 0);
    end else begin
      checkValue("rdReqValid_o requests", reqRises - riseMark[idx], 1);
      checkValue("rdAddr_o", lastReqAddr, stimAddr[idx] & 32'hFFFF_FFE0);
    end
  endtask

  task automatic runRequests();
    int next;
    int retired;
    int stall;
    int idx;
    next    = 0;
    retired = 0;
    stall   = 0;
    while (retired < numReqs) begin
      @(negedge clk);
      cyc++;
      stall++;
      if (stall > stallLimit) begin
        reportFail($sformatf("timeout: request %0d returned no data in %0d cycles",
                             retired, stallLimit));
      end
      if (dut_i.asserts_i.failCount != 0) begin
        reportFail("a bus protocol assertion failed");
      end
      // one rising edge of rdReqValid_o per line request
      if (rdReqValid) begin
        reqCycles++;
        if (!prevReqValid) begin
          reqRises++;
          lastReqAddr = rdAddr;
        end
      end
      prevReqValid = rdReqValid;
      if (dataOk) begin
        if (pending.size() == 0) begin
          reportFail("dataOk_o went high with no request outstanding");
        end else begin
          idx = pending.pop_front();
          retireCheck(idx);
          retired++;
          stall = 0;
        end
      end
      // valid stays high through a run of hits
      if (pending.size() == 0 && next < numReqs) begin
        if (next > 0 && expHit[next] && expHit[next-1] && acceptCyc[next-1] == cyc - 1) begin
          checkValue("addrOk_o", addrOk, 1);
        end
        valid = 1'b1;
        addr  = stimAddr[next];
        if (addrOk) begin
          acceptCyc[next] = cyc;
          reqMark[next]   = reqCycles;
          riseMark[next]  = reqRises;
          pending.push_back(next);
          next++;
        end
      end else begin
        valid = 1'b0;
      end
    end
  endtask

  initial begin
    valid        = 1'b0;
    addr         = '0;
    rst_n        = 1'b0;
    cyc          = 0;
    reqCycles    = 0;
    reqRises     = 0;
    prevReqValid = 1'b0;
    lastReqAddr  = '0;
    loadStimulus();
    repeat (16) @(negedge clk);
    checkValue("addrOk_o", addrOk, 1);
    checkValue("dataOk_o", dataOk, 0);
    checkValue("rdReqValid_o", rdReqValid, 0);
    rst_n = 1'b1;
    runRequests();
    if (dut_i.asserts_i.failCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // bus memory model where the word at byte address A is {A, ~A}
  initial begin
    seed         = 99003;
    rdReqReady   = 1'b0;
    rdDataValid  = 1'b0;
    rdBeat       = '0;
    rdLast       = 1'b0;
    handshakeDue = 1'b0;
    beatsActive  = 1'b0;
    beatIdx      = 0;
    busAddr      = '0;
    beatAddr     = '0;
    forever begin
      @(negedge clk);
      // beat driven last cycle was taken at the rising edge
      if (rdDataValid) begin
        beatIdx++;
        if (beatIdx == busPkg::beatsPerLine) begin
          beatsActive = 1'b0;
        end
      end
      if (handshakeDue) begin
        handshakeDue = 1'b0;
        beatsActive  = 1'b1;
        beatIdx      = 0;
      end
      rdReqReady = rst_n && (({$random(seed)} % 3) == 0);
      if (rdReqValid && rdReqReady) begin
        handshakeDue = 1'b1;
        busAddr      = rdAddr;
      end
      if (beatsActive) begin
        beatAddr    = busAddr + 8 * beatIdx;
        rdDataValid = ({$random(seed)} % 3) != 0;
        rdBeat      = {beatAddr, ~beatAddr};
        rdLast      = rdDataValid && beatIdx == busPkg::beatsPerLine - 1;
      end else begin
        rdDataValid = 1'b0;
        rdLast      = 1'b0;
      end
    end
  end

endmodule

// ==== bench/cache_asserts.sv ====
`timescale 1ns/100ps

module cache_asserts (
  input logic                           clk,
  input logic                           rst_n,
  input logic                           dataOk_i,
  input logic                           rdReqValid_i,
  input logic                           rdReqReady_i,
  input logic [cachePkg::addrWidth-1:0] rdAddr_i,
  input logic                           rdDataValid_i
);

  // count of failed assertions
  int failCount = 0;

  noDataDuringReq: assert property (@(posedge clk) disable iff (!rst_n)
    !(dataOk_i && rdReqValid_i))
    else begin
      failCount++;
      $error("dataOk_o and rdReqValid_o high in the same cycle");
    end

  // request held with the same address until taken
  reqAddrHeld: assert property (@(posedge clk) disable iff (!rst_n)
    rdReqValid_i && !rdReqReady_i |=> rdReqValid_i && $stable(rdAddr_i))
    else begin
      failCount++;
      $error("rdAddr_o changed or request dropped before rdReqReady_i");
    end

  reqAddrAligned: assert property (@(posedge clk) disable iff (!rst_n)
    rdReqValid_i |-> rdAddr_i[cachePkg::offsetWidth-1:0] == '0)
    else begin
      failCount++;
      $error("rdAddr_o is not line aligned");
    end

  noBeatBeforeAccept: assert property (@(posedge clk) disable iff (!rst_n)
    rdReqValid_i |-> !rdDataValid_i)
    else begin
      failCount++;
      $error("rdDataValid_i high while the line request is pending");
    end

endmodule

bind cacheTop cache_asserts asserts_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .dataOk_i     (dataOk_o),
  .rdReqValid_i (rdReqValid_o),
  .rdReqReady_i (rdReqReady_i),
  .rdAddr_i     (rdAddr_o),
  .rdDataValid_i(rdDataValid_i)
);

// ==== bench/clockGen.sv ====
`timescale 1ns/100ps

module clockGen #(
  parameter int halfPeriod = 2
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  // 4 ns period
  always begin
    #halfPeriod clk_o = ~clk_o;
  end

endmodule

// ==== src/cacheTop.sv ====
`timescale 1ns/100ps

module cacheTop #(
  parameter int numSets = cachePkg::numSets
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           valid_i,
  input  logic [cachePkg::addrWidth-1:0] addr_i,
  output logic                           addrOk_o,
  output logic                           dataOk_o,
  output logic [cachePkg::wordWidth-1:0] rdData_o,
  output logic                           rdReqValid_o,
  output logic [cachePkg::addrWidth-1:0] rdAddr_o,
  input  logic                           rdReqReady_i,
  input  logic                           rdDataValid_i,
  input  logic [busPkg::beatWidth-1:0]   rdData_i,
  input  logic                           rdLast_i
);

  logic                           ramEn;
  logic [$clog2(numSets)-1:0]     ramIndex;
  logic                           we0;
  logic                           we1;
  cachePkg::tagT                  wrTag;
  cachePkg::lineT                 wrLine;
  cachePkg::tagT                  tagQ0;
  cachePkg::tagT                  tagQ1;
  cachePkg::lineT                 lineQ0;
  cachePkg::lineT                 lineQ1;
  logic                           refillStart;
  logic [cachePkg::addrWidth-1:0] missLineAddr;
  logic                           refillDone;
  cachePkg::lineT                 refillLine;

  cacheCtrl #(
    .numSets(numSets)
  ) ctrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_i       (valid_i),
    .addr_i        (addr_i),
    .addrOk_o      (addrOk_o),
    .dataOk_o      (dataOk_o),
    .rdData_o      (rdData_o),
    .tagQ0_i       (tagQ0),
    .tagQ1_i       (tagQ1),
    .lineQ0_i      (lineQ0),
    .lineQ1_i      (lineQ1),
    .ramEn_o       (ramEn),
    .ramIndex_o    (ramIndex),
    .we0_o         (we0),
    .we1_o         (we1),
    .wrTag_o       (wrTag),
    .wrLine_o      (wrLine),
    .refillStart_o (refillStart),
    .missLineAddr_o(missLineAddr),
    .refillDone_i  (refillDone),
    .refillLine_i  (refillLine)
  );

  refillUnit refill_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .refillStart_i(refillStart),
    .lineAddr_i   (missLineAddr),
    .rdReqValid_o (rdReqValid_o),
    .rdAddr_o     (rdAddr_o),
    .rdReqReady_i (rdReqReady_i),
    .rdDataValid_i(rdDataValid_i),
    .rdData_i     (rdData_i),
    .rdLast_i     (rdLast_i),
    .refillDone_o (refillDone),
    .line_o       (refillLine)
  );

  // tag storage per way
  sramModel #(.numSets(numSets), .entryT(cachePkg::tagT)) tagRam0_i (
    .clk(clk), .en_i(ramEn), .we_i(we0), .addr_i(ramIndex),
    .wrData_i(wrTag), .rdData_o(tagQ0)
  );

  sramModel #(.numSets(numSets), .entryT(cachePkg::tagT)) tagRam1_i (
    .clk(clk), .en_i(ramEn), .we_i(we1), .addr_i(ramIndex),
    .wrData_i(wrTag), .rdData_o(tagQ1)
  );

  // line storage per way
  sramModel #(.numSets(numSets), .entryT(cachePkg::lineT)) dataRam0_i (
    .clk(clk), .en_i(ramEn), .we_i(we0), .addr_i(ramIndex),
    .wrData_i(wrLine), .rdData_o(lineQ0)
  );

  sramModel #(.numSets(numSets), .entryT(cachePkg::lineT)) dataRam1_i (
    .clk(clk), .en_i(ramEn), .we_i(we1), .addr_i(ramIndex),
    .wrData_i(wrLine), .rdData_o(lineQ1)
  );

endmodule

// ==== src/cacheCtrl.sv ====
`timescale 1ns/100ps

module cacheCtrl #(
  parameter int numSets = 64
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           valid_i,
  input  logic [cachePkg::addrWidth-1:0] addr_i,
  output logic                           addrOk_o,
  output logic                           dataOk_o,
  output logic [cachePkg::wordWidth-1:0] rdData_o,
  input  cachePkg::tagT                  tagQ0_i,
  input  cachePkg::tagT                  tagQ1_i,
  input  cachePkg::lineT                 lineQ0_i,
  input  cachePkg::lineT                 lineQ1_i,
  output logic                           ramEn_o,
  output logic [$clog2(numSets)-1:0]     ramIndex_o,
  output logic                           we0_o,
  output logic                           we1_o,
  output cachePkg::tagT                  wrTag_o,
  output cachePkg::lineT                 wrLine_o,
  output logic                           refillStart_o,
  output logic [cachePkg::addrWidth-1:0] missLineAddr_o,
  input  logic                           refillDone_i,
  input  cachePkg::lineT                 refillLine_i
);

  localparam int idxW   = $clog2(numSets);
  localparam int tagLsb = cachePkg::offsetWidth + cachePkg::indexWidth;

  typedef enum logic [2:0] {
    idleSt,
    compareSt,
    missSt,
    refillSt,
    fillSt
  } stateT;

  stateT                          curState;
  stateT                          nextState;
  logic [cachePkg::addrWidth-1:0] reqAddr;
  logic [idxW-1:0]                reqIndex;
  cachePkg::tagT                  reqTag;
  logic [1:0]                     wordSel;
  logic [numSets-1:0]             valid0;
  logic [numSets-1:0]             valid1;
  logic [numSets-1:0]             lruWay;
  logic                           compareEn;
  logic                           hit0;
  logic                           hit1;
  logic                           miss;
  logic                           accept;
  logic                           victimSel;
  logic                           victimWay;
  cachePkg::lineT                 hitLine;

  // fields of the request under compare
  assign reqIndex = reqAddr[cachePkg::offsetWidth +: idxW];
  assign reqTag   = reqAddr[tagLsb +: cachePkg::tagWidth];
  assign wordSel  = reqAddr[cachePkg::offsetWidth-1 -: 2];

  assign compareEn = curState == compareSt;
  assign hit0      = compareEn && valid0[reqIndex] && (tagQ0_i == reqTag);
  assign hit1      = compareEn && valid1[reqIndex] && (tagQ1_i == reqTag);
  assign miss      = compareEn && !hit0 && !hit1;

  // a hit frees the front end for the next request
  assign addrOk_o = (curState == idleSt) || hit0 || hit1;
  assign dataOk_o = hit0 || hit1;
  assign accept   = valid_i && addrOk_o;

  assign hitLine  = hit1 ? lineQ1_i : lineQ0_i;
  assign rdData_o = hitLine[wordSel*cachePkg::wordWidth +: cachePkg::wordWidth];

  // invalid way first and otherwise the least recently used one
  assign victimSel = !valid0[reqIndex] ? 1'b0 :
                     !valid1[reqIndex] ? 1'b1 : lruWay[reqIndex];

  // RAM index comes from the new request or from the held one during fill
  assign ramEn_o    = accept || (curState == refillSt) || (curState == fillSt);
  assign ramIndex_o = accept ? addr_i[cachePkg::offsetWidth +: idxW] : reqIndex;
  assign we0_o      = (curState == refillSt) && !victimWay;
  assign we1_o      = (curState == refillSt) && victimWay;
  assign wrTag_o    = reqTag;
  assign wrLine_o   = refillLine_i;

  assign refillStart_o  = miss;
  assign missLineAddr_o = {reqAddr[cachePkg::addrWidth-1:cachePkg::offsetWidth],
                           {cachePkg::offsetWidth{1'b0}}};

  always_comb begin
    nextState = curState;
    case (curState)
      idleSt:    nextState = accept ? compareSt : idleSt;
      compareSt: begin
        if (miss) begin
          nextState = missSt;
        end else if (!valid_i) begin
          nextState = idleSt;
        end
      end
      missSt:    nextState = refillDone_i ? refillSt : missSt;
      // a write cycle and then a read cycle so compare sees the new line
      refillSt:  nextState = fillSt;
      fillSt:    nextState = compareSt;
      default:   nextState = idleSt;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      curState  <= idleSt;
      victimWay <= 1'b0;
      valid0    <= '0;
      valid1    <= '0;
      lruWay    <= '0;
    end else begin
      curState <= nextState;
      if (miss) begin
        victimWay <= victimSel;
      end
      if (curState == refillSt) begin
        if (victimWay) begin
          valid1[reqIndex] <= 1'b1;
        end else begin
          valid0[reqIndex] <= 1'b1;
        end
      end
      // lru points at the way not just used
      if (hit0 || hit1) begin
        lruWay[reqIndex] <= hit0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= addr_i;
    end
  end

endmodule

// ==== src/refillUnit.sv ====
`timescale 1ns/100ps

module refillUnit (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           refillStart_i,
  input  logic [cachePkg::addrWidth-1:0] lineAddr_i,
  output logic                           rdReqValid_o,
  output logic [cachePkg::addrWidth-1:0] rdAddr_o,
  input  logic                           rdReqReady_i,
  input  logic                           rdDataValid_i,
  input  logic [busPkg::beatWidth-1:0]   rdData_i,
  input  logic                           rdLast_i,
  output logic                           refillDone_o,
  output cachePkg::lineT                 line_o
);

  logic                                                 beatsPending;
  logic                                                 beatTake;
  logic [busPkg::beatCountWidth-1:0]                    beatCnt;
  logic [busPkg::beatsPerLine-1:0][busPkg::beatWidth-1:0] beats;

  assign beatTake = beatsPending && rdDataValid_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdReqValid_o <= 1'b0;
      rdAddr_o     <= '0;
      beatsPending <= 1'b0;
      beatCnt      <= '0;
      refillDone_o <= 1'b0;
    end else begin
      // done one cycle after the last beat once the line is complete
      refillDone_o <= beatTake && rdLast_i;

      // request level held until the bus takes it
      if (refillStart_i) begin
        rdReqValid_o <= 1'b1;
        rdAddr_o     <= {lineAddr_i[cachePkg::addrWidth-1:cachePkg::offsetWidth],
                         {cachePkg::offsetWidth{1'b0}}};
      end else if (rdReqValid_o && rdReqReady_i) begin
        rdReqValid_o <= 1'b0;
      end

      if (rdReqValid_o && rdReqReady_i) begin
        beatsPending <= 1'b1;
      end else if (beatTake && rdLast_i) begin
        beatsPending <= 1'b0;
      end

      if (beatTake) begin
        beatCnt <= rdLast_i ? '0 : beatCnt + 1'b1;
      end
    end
  end

  // lowest address beat lands in the low word
  always_ff @(posedge clk) begin
    if (beatTake) begin
      beats[beatCnt] <= rdData_i;
    end
  end

  assign line_o = beats;

endmodule

// ==== src/sramModel.sv ====
`timescale 1ns/100ps

module sramModel #(
  parameter int  numSets = 64,
  parameter type entryT  = logic [7:0]
) (
  input  logic                       clk,
  input  logic                       en_i,
  input  logic                       we_i,
  input  logic [$clog2(numSets)-1:0] addr_i,
  input  entryT                      wrData_i,
  output entryT                      rdData_o
);

  entryT mem [numSets];

  // a write cycle leaves the read register unchanged
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wrData_i;
      end else begin
        rdData_o <= mem[addr_i];
      end
    end
  end

endmodule

// ==== src/busPkg.sv ====
package busPkg;

  // refill bus data path
  localparam int beatWidth = 64;

  // beats per line refill and the counter that walks them
  localparam int beatsPerLine   = 4;
  localparam int beatCountWidth = $clog2(beatsPerLine);

endpackage

// ==== src/cachePkg.sv ====
package cachePkg;

  // address layout is tag | index | offset
  localparam int addrWidth   = 32;
  localparam int wordWidth   = 64;
  localparam int offsetWidth = 5;
  localparam int indexWidth  = 6;
  localparam int tagWidth    = addrWidth - indexWidth - offsetWidth;

  // derived geometry
  localparam int numSets   = 1 << indexWidth;
  localparam int lineWidth = 8 << offsetWidth;

  // tag RAM entry
  typedef logic [tagWidth-1:0] tagT;

  // data RAM entry, one full line
  typedef logic [lineWidth-1:0] lineT;

endpackage
